//--- design/mult_rev_collect.sv
// Outputs are registered and held at zero whenever out_valid is low; fault is only set backward
`timescale 1ns/1ps
`default_nettype none

module mult_rev_collect
    import mult_rev_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  row_state_t  stage_in,
    output logic        out_valid,
    output dir_e        out_dir,
    output rev_record_t fwd_out,
    output operands_t   bwd_out,
    output logic        fault
);

    rev_record_t fwd_nxt;
    operands_t   bwd_nxt;
    logic        fault_nxt;

    // Forward packs the record, backward hands back the operands
    always_comb begin
        fwd_nxt   = '0;
        bwd_nxt   = '0;
        fault_nxt = 1'b0;
        if (stage_in.dir == DIR_FWD) begin
            fwd_nxt.product = stage_in.acc;
            fwd_nxt.row_rec = stage_in.row_rec;
            fwd_nxt.a_rec   = stage_in.a;
        end else begin
            bwd_nxt.a = stage_in.a;
            bwd_nxt.b = stage_in.b;
            // Anything left in the accumulator means the record did not match
            fault_nxt = stage_in.row_fault | (stage_in.acc != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !stage_in.valid) begin
            out_valid <= 1'b0;
            out_dir   <= DIR_FWD;
            fwd_out   <= '0;
            bwd_out   <= '0;
            fault     <= 1'b0;
        end else begin
            out_valid <= 1'b1;
            out_dir   <= stage_in.dir;
            fwd_out   <= fwd_nxt;
            bwd_out   <= bwd_nxt;
            fault     <= fault_nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/mult_rev_launch.sv
// Samples one item per cycle when in_valid is high; the input group not chosen by dir is ignored
`timescale 1ns/1ps
`default_nettype none

module mult_rev_launch
    import mult_rev_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  dir_e        dir,
    input  operands_t   fwd_in,
    input  rev_record_t bwd_in,
    output row_state_t  stage_out
);

    row_state_t nxt;
    row_state_t data_q;
    logic       valid_q;

    // Initial row state for either direction
    always_comb begin
        nxt           = '0;
        nxt.valid     = in_valid;
        nxt.dir       = dir;
        nxt.row_fault = 1'b0;
        if (dir == DIR_FWD) begin
            nxt.a       = fwd_in.a;
            nxt.b       = fwd_in.b;
            nxt.acc     = '0;
            nxt.row_rec = '0;
        end else begin
            // Backward starts from the product and strips rows off again
            nxt.a       = bwd_in.a_rec;
            nxt.b       = '0;
            nxt.acc     = bwd_in.product;
            nxt.row_rec = bwd_in.row_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= nxt.valid;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= nxt;
    end

    always_comb begin
        stage_out       = data_q;
        stage_out.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- design/mult_rev_pkg.sv
// Widths are fixed at 8x8 operands and one row stage per bit of b; not meant to be rescaled
`default_nettype none

package mult_rev_pkg;

    // ====================
    // Sizes and timing
    // ====================
    localparam int OP_W     = 8;
    localparam int PROD_W   = 16;
    localparam int NUM_ROWS = 8;

    // Launch stage, one stage per row, then the collect stage
    localparam int LATENCY  = NUM_ROWS + 2;

    // ====================
    // Types
    // ====================

    // Direction travels with every item through the pipe
    typedef enum logic {
        DIR_FWD = 1'b0,
        DIR_BWD = 1'b1
    } dir_e;

    // Forward input group and backward output group
    typedef struct packed {
        logic [OP_W-1:0] a;
        logic [OP_W-1:0] b;
    } operands_t;

    // Forward output group and backward input group
    typedef struct packed {
        logic [PROD_W-1:0]                product;
        logic [NUM_ROWS-1:0][OP_W-1:0]    row_rec;
        logic [OP_W-1:0]                  a_rec;
    } rev_record_t;

    // State handed from one pipeline stage to the next
    typedef struct packed {
        logic                             valid;
        dir_e                             dir;
        logic [OP_W-1:0]                  a;
        // Given forward, rebuilt bit by bit backward
        logic [OP_W-1:0]                  b;
        logic [PROD_W-1:0]                acc;
        logic [NUM_ROWS-1:0][OP_W-1:0]    row_rec;
        logic                             row_fault;
    } row_state_t;

endpackage

`default_nettype wire

//--- design/mult_rev_row.sv
// One row per bit of b; ROW_IDX must lie in 0..NUM_ROWS-1 and rows must run in index order
`timescale 1ns/1ps
`default_nettype none

module mult_rev_row
    import mult_rev_pkg::*;
#(
    parameter int ROW_IDX = 0
) (
    input  wire        clk,
    input  wire        rst_n,
    input  row_state_t stage_in,
    output row_state_t stage_out
);

    row_state_t        nxt;
    row_state_t        data_q;
    logic              valid_q;
    logic [PROD_W-1:0] addend;
    logic [OP_W-1:0]   rec_byte;
    logic              take;
    logic              byte_bad;

    // a weighted by this row's bit position
    assign addend   = PROD_W'(stage_in.a) << ROW_IDX;
    assign rec_byte = stage_in.row_rec[ROW_IDX];

    // ====================
    // Row rule
    // ====================
    always_comb begin
        nxt      = stage_in;
        take     = 1'b0;
        byte_bad = 1'b0;
        if (stage_in.dir == DIR_FWD) begin
            take = stage_in.b[ROW_IDX];
            // Record holds a when the row added, its complement otherwise
            nxt.row_rec[ROW_IDX] = take ? stage_in.a : ~stage_in.a;
            if (take) begin
                nxt.acc = stage_in.acc + addend;
            end
        end else begin
            take               = (rec_byte == stage_in.a);
            byte_bad           = !take && (rec_byte != ~stage_in.a);
            nxt.b[ROW_IDX]     = take;
            nxt.row_fault      = stage_in.row_fault | byte_bad;
            if (take) begin
                nxt.acc = stage_in.acc - addend;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= nxt;
    end

    always_comb begin
        stage_out       = data_q;
        stage_out.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- design/mult_rev_top.sv
// Fixed LATENCY of 10 cycles with no back-pressure; results must be taken when out_valid is high
`timescale 1ns/1ps
`default_nettype none

module mult_rev_top
    import mult_rev_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  dir_e        dir,
    input  operands_t   fwd_in,
    input  rev_record_t bwd_in,
    output logic        out_valid,
    output dir_e        out_dir,
    output rev_record_t fwd_out,
    output operands_t   bwd_out,
    output logic        fault
);

    // stage[0] from launch, stage[NUM_ROWS] into collect
    row_state_t stage [NUM_ROWS+1];

    mult_rev_launch u_launch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .dir       (dir),
        .fwd_in    (fwd_in),
        .bwd_in    (bwd_in),
        .stage_out (stage[0])
    );

    // ====================
    // Row pipeline
    // ====================
    for (genvar i = 0; i < NUM_ROWS; i++) begin : g_row
        mult_rev_row #(
            .ROW_IDX (i)
        ) u_row (
            .clk       (clk),
            .rst_n     (rst_n),
            .stage_in  (stage[i]),
            .stage_out (stage[i+1])
        );
    end

    mult_rev_collect u_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (stage[NUM_ROWS]),
        .out_valid (out_valid),
        .out_dir   (out_dir),
        .fwd_out   (fwd_out),
        .bwd_out   (bwd_out),
        .fault     (fault)
    );

endmodule

`default_nettype wire

//--- list.f
design/mult_rev_pkg.sv
design/mult_rev_launch.sv
design/mult_rev_row.sv
design/mult_rev_collect.sv
design/mult_rev_top.sv
verif/mult_rev_asserts.sv
verif/mult_rev_tb.sv

//--- verif/mult_rev_asserts.sv
// Bound to mult_rev_top; the latency check assumes no reset while items are in flight
`timescale 1ns/1ps
`default_nettype none

module mult_rev_asserts
    import mult_rev_pkg::*;
(
    input wire         clk,
    input wire         rst_n,
    input wire         in_valid,
    input wire         out_valid,
    input dir_e        out_dir,
    input rev_record_t fwd_out,
    input operands_t   bwd_out,
    input wire         fault
);

    // Collect clears on the reset edge
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high while in reset");

    a_latency_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##LATENCY out_valid)
        else $error("out_valid did not follow in_valid after LATENCY cycles");

    a_latency_bwd: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, LATENCY))
        else $error("out_valid without an input LATENCY cycles earlier");

    a_fault_dir: assert property (@(posedge clk) disable iff (!rst_n)
        fault |-> out_dir == DIR_BWD)
        else $error("fault raised on a forward item");

    // ====================
    // Unused group held at zero
    // ====================
    a_bwd_zero: assert property (@(posedge clk) disable iff (!rst_n)
        out_dir == DIR_FWD |-> bwd_out == '0)
        else $error("bwd_out not zero for a forward item");

    a_fwd_zero: assert property (@(posedge clk) disable iff (!rst_n)
        out_dir == DIR_BWD |-> fwd_out == '0)
        else $error("fwd_out not zero for a backward item");

endmodule

bind mult_rev_top mult_rev_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_dir   (out_dir),
    .fwd_out   (fwd_out),
    .bwd_out   (bwd_out),
    .fault     (fault)
);

`default_nettype wire

//--- verif/mult_rev_tb.sv
// Self-checking testbench; expects LATENCY from the package to match the DUT's real pipe depth
`timescale 1ns/1ps
`default_nettype none

module mult_rev_tb
    import mult_rev_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_FWD     = 44;
    localparam int NUM_MIX     = 60;
    localparam int NUM_FAULT   = 20;
    localparam int TOTAL_ITEMS = 2 * NUM_FWD + NUM_MIX + 2 * NUM_FAULT;
    // Item count plus room for reset, idle time and the drain after each phase
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS + LATENCY + 20 + 4 * (LATENCY + 2);

    typedef struct packed {
        dir_e        dir;
        rev_record_t fwd;
        operands_t   bwd;
        logic        fault;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    dir_e        dir;
    operands_t   fwd_in;
    rev_record_t bwd_in;
    logic        out_valid;
    dir_e        out_dir;
    rev_record_t fwd_out;
    operands_t   bwd_out;
    logic        fault;

    integer      seed;
    int unsigned neg_cycle = 0;
    logic        capture_fwd;
    exp_t        exp_q[$];
    int unsigned in_cycle_q[$];
    rev_record_t rt_q[$];
    operands_t   orig_q[$];

    mult_rev_top u_mult_rev_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .dir       (dir),
        .fwd_in    (fwd_in),
        .bwd_in    (bwd_in),
        .out_valid (out_valid),
        .out_dir   (out_dir),
        .fwd_out   (fwd_out),
        .bwd_out   (bwd_out),
        .fault     (fault)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    task automatic abort_run(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "Stopping after the first error");
    endtask

    task automatic report_mismatch(input string what);
        $display("Mismatch at time %0t: %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "Stopping after the first mismatch");
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] v;
        v = $random(seed);
        return v[7:0];
    endfunction

    // Forward multiplies and records a or ~a per b bit; backward recovers b from
    // the records, and the rows leave a nonzero remainder exactly when product != a*b
    function automatic exp_t ref_model(input dir_e d, input operands_t f, input rev_record_t r);
        exp_t              e;
        logic [PROD_W-1:0] prod;
        e     = '0;
        e.dir = d;
        if (d == DIR_FWD) begin
            e.fwd.product = PROD_W'(f.a) * PROD_W'(f.b);
            for (int i = 0; i < NUM_ROWS; i++) begin
                e.fwd.row_rec[i] = f.b[i] ? f.a : ~f.a;
            end
            e.fwd.a_rec = f.a;
        end else begin
            e.bwd.a = r.a_rec;
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (r.row_rec[i] == r.a_rec) begin
                    e.bwd.b[i] = 1'b1;
                end else if (r.row_rec[i] != ~r.a_rec) begin
                    e.fault = 1'b1;
                end
            end
            prod = PROD_W'(e.bwd.a) * PROD_W'(e.bwd.b);
            if (prod != r.product) begin
                e.fault = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic drive_item(input dir_e d, input operands_t f, input rev_record_t r,
                              input exp_t e);
        @(posedge clk);
        in_valid <= 1'b1;
        dir      <= d;
        fwd_in   <= f;
        bwd_in   <= r;
        exp_q.push_back(e);
    endtask

    task automatic wait_drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin : stimulus
        operands_t   ops;
        rev_record_t rec;
        exp_t        e;
        logic [7:0]  mask;
        int          idx;
        seed        = 32'hb0f7_a22f;
        capture_fwd = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        dir         = DIR_FWD;
        fwd_in      = '0;
        bwd_in      = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // Idle after reset, the compare process flags any stray out_valid
        repeat (LATENCY + 2) @(posedge clk);

        // Forward corners first, then random operands
        capture_fwd = 1'b1;
        for (int n = 0; n < NUM_FWD; n++) begin
            ops.a = rand_byte();
            ops.b = rand_byte();
            case (n)
                0: ops.a = 8'h00;
                1: ops.b = 8'h00;
                2: ops = {8'hff, 8'hff};
                default: ;
            endcase
            orig_q.push_back(ops);
            drive_item(DIR_FWD, ops, '0, ref_model(DIR_FWD, ops, '0));
        end
        wait_drain();
        capture_fwd = 1'b0;

        // Round trip must hand back the original operands
        while (rt_q.size() > 0) begin
            rec   = rt_q.pop_front();
            e     = '0;
            e.dir = DIR_BWD;
            e.bwd = orig_q.pop_front();
            drive_item(DIR_BWD, '0, rec, e);
        end
        wait_drain();

        // Mixed directions, one item every cycle
        for (int n = 0; n < NUM_MIX; n++) begin
            ops.a = rand_byte();
            ops.b = rand_byte();
            rec   = ref_model(DIR_FWD, ops, '0).fwd;
            if (rand_byte() < 8'h80) begin
                drive_item(DIR_FWD, ops, rec, ref_model(DIR_FWD, ops, rec));
            end else begin
                drive_item(DIR_BWD, ops, rec, ref_model(DIR_BWD, ops, rec));
            end
        end

        // Broken records: product off by one, then one row byte corrupted
        for (int n = 0; n < NUM_FAULT; n++) begin
            ops.a = rand_byte();
            ops.b = rand_byte();
            rec   = ref_model(DIR_FWD, ops, '0).fwd;
            rec.product = rec.product + 1'b1;
            drive_item(DIR_BWD, '0, rec, ref_model(DIR_BWD, '0, rec));
            rec  = ref_model(DIR_FWD, ops, '0).fwd;
            idx  = rand_byte() % NUM_ROWS;
            mask = rand_byte();
            if (mask == 8'h00 || mask == 8'hff) begin
                mask = 8'h5a;
            end
            rec.row_rec[idx] = ops.a ^ mask;
            drive_item(DIR_BWD, '0, rec, ref_model(DIR_BWD, '0, rec));
        end
        wait_drain();

        $display("Testbench passed");
        $finish;
    end

    // ====================
    // Compare
    // ====================
    always @(negedge clk) begin : compare
        exp_t        e;
        int unsigned t_in;
        neg_cycle = neg_cycle + 1;
        if (!rst_n) begin
            assert (!out_valid) else abort_run("out_valid was high during reset");
        end else begin
            if (in_valid) begin
                in_cycle_q.push_back(neg_cycle);
            end
            if (out_valid) begin
                assert (exp_q.size() > 0) else abort_run("out_valid rose with no item in flight");
                e    = exp_q.pop_front();
                t_in = in_cycle_q.pop_front();
                assert (neg_cycle - t_in == LATENCY) else report_mismatch(
                    $sformatf("latency %0d, expected %0d", neg_cycle - t_in, LATENCY));
                assert (out_dir == e.dir) else report_mismatch(
                    $sformatf("out_dir %0d, expected %0d", out_dir, e.dir));
                assert (fwd_out == e.fwd) else report_mismatch(
                    $sformatf("fwd_out %h, expected %h", fwd_out, e.fwd));
                assert (bwd_out == e.bwd) else report_mismatch(
                    $sformatf("bwd_out %h, expected %h", bwd_out, e.bwd));
                assert (fault == e.fault) else report_mismatch(
                    $sformatf("fault %b, expected %b", fault, e.fault));
                if (capture_fwd && out_dir == DIR_FWD) begin
                    rt_q.push_back(fwd_out);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
